// File: all.f
+incdir+hdl
hdl/lc3b_types.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/alu.sv
hdl/cc_unit.sv
hdl/mem_stall.sv
hdl/datapath.sv
hdl/lc3b_cpu.sv
testbench/tb_lc3b_memory.sv
testbench/tb_lc3b_cpu.sv

// File: Bender.yml
package:
  name: lc3b_cpu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lc3b_types.sv
      - hdl/control_rom.sv
      - hdl/regfile.sv
      - hdl/alu.sv
      - hdl/cc_unit.sv
      - hdl/mem_stall.sv
      - hdl/datapath.sv
      - hdl/lc3b_cpu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_lc3b_memory.sv
      - testbench/tb_lc3b_cpu.sv

// File: testbench/tb_lc3b_cpu.sv
`include "lc3b_defs.svh"

module tb_lc3b_cpu;
	timeunit 1ns;
	timeprecision 1ps;
	import lc3b_types::*;

	typedef struct packed {
		lc3b_word addr;
		lc3b_word data;
	} store_t;

	localparam int mem_words = 256;
	localparam logic [3:0] add_op = 4'b0001;
	localparam logic [3:0] and_op = 4'b0101;

	logic clk, reset, random_delay;
	logic inst_read, inst_resp, data_read, data_write, data_resp, store_valid;
	lc3b_word inst_address, inst_rdata, data_address, data_wdata, data_rdata;
	lc3b_word store_addr, store_data;
	lc3b_word image [mem_words];
	lc3b_word prog [$];
	store_t expected [$];
	lc3b_word halt_pc;
	int halt_fetches;
	int store_idx;
	int cycles;
	int limit;
	logic str_fetched;
	string test_name;

	lc3b_cpu i_lc3b_cpu (.*);

	tb_lc3b_memory i_memory (.*);

	function automatic lc3b_word enc_alu(input logic [3:0] op, input int dr, input int sr1,
		input logic imm, input int b);
		return {op, 3'(dr), 3'(sr1), imm, imm ? 5'(b) : {2'b00, 3'(b)}};
	endfunction

	function automatic lc3b_word enc_not(input int dr, input int sr);
		return {4'b1001, 3'(dr), 3'(sr), 6'b111111};
	endfunction

	function automatic lc3b_word enc_mem(input logic [3:0] op, input int r, input int base,
		input int off);
		return {op, 3'(r), 3'(base), 6'(off)};
	endfunction

	function automatic lc3b_word enc_br(input logic [2:0] nzp, input int off);
		return {4'b0000, nzp, 9'(off)};
	endfunction

	function automatic lc3b_word sext(input lc3b_word v, input int bits);
		lc3b_word m;
		m = 16'hFFFF << bits;
		return v[bits-1] ? (v | m) : (v & ~m);
	endfunction

	// Three NOPs after each instruction cover every data and branch hazard
	task automatic emit(input lc3b_word w);
		prog.push_back(w);
		repeat (3) prog.push_back(`LC3B_NOP);
	endtask

	task automatic build_program();
		emit(enc_not(1, 0));
		emit(enc_alu(add_op, 1, 1, 1'b1, -1));	// R1 = FFFE, base of the data area
		emit(enc_alu(add_op, 2, 0, 1'b1, 13));
		emit(enc_alu(add_op, 3, 0, 1'b1, -6));
		emit(enc_alu(add_op, 4, 2, 1'b0, 3));
		emit(enc_mem(4'b0111, 4, 1, -1));
		emit(enc_alu(and_op, 5, 2, 1'b1, -4));
		emit(enc_mem(4'b0111, 5, 1, -2));
		emit(enc_alu(and_op, 6, 3, 1'b0, 2));
		emit(enc_mem(4'b0111, 6, 1, -3));
		emit(enc_not(7, 3));
		emit(enc_mem(4'b0111, 7, 1, -4));
		emit(enc_mem(4'b0110, 2, 1, -20));
		emit(enc_mem(4'b0111, 2, 1, -21));
		// Offset 7 skips exactly one spaced instruction
		emit(enc_not(3, 7));
		emit(enc_br(3'b100, 7));
		emit(enc_mem(4'b0111, 3, 1, -5));
		emit(enc_mem(4'b0111, 7, 1, -6));
		emit(enc_br(3'b010, 7));
		emit(enc_mem(4'b0111, 3, 1, -7));
		emit(enc_alu(and_op, 3, 3, 1'b1, 0));
		emit(enc_br(3'b010, 7));
		emit(enc_mem(4'b0111, 2, 1, -8));
		emit(enc_br(3'b101, 7));
		emit(enc_mem(4'b0111, 4, 1, -9));
		emit(enc_alu(add_op, 3, 3, 1'b1, 9));
		emit(enc_br(3'b001, 7));
		emit(enc_mem(4'b0111, 5, 1, -10));
		emit(enc_br(3'b100, 7));
		emit(enc_mem(4'b0111, 3, 1, -11));
		emit(enc_br(3'b110, 7));
		emit(enc_mem(4'b0111, 6, 1, -12));
		emit(enc_br(3'b011, 7));
		emit(enc_mem(4'b0111, 4, 1, -13));
		emit(enc_br(3'b111, -1));	// Self branch ends the program
	endtask

	// Architectural model of the ISA subset, run in order on its own copy of memory
	function automatic void compute_expected();
		lc3b_word mem [mem_words];
		lc3b_word r [8];
		logic [2:0] cc;
		logic wr;
		lc3b_word pc, ir, addr, b, res, target;
		mem = image;
		r = '{default: '0};
		cc = 3'b010;
		pc = `LC3B_RESET_PC;
		expected.delete();
		for (int steps = 0; steps < 10000; steps++) begin
			ir = mem[pc[8:1]];
			pc = pc + 16'd2;
			b = ir[5] ? sext(ir, 5) : r[ir[2:0]];
			addr = r[ir[8:6]] + (sext(ir, 6) << 1);
			target = pc + (sext(ir, 9) << 1);
			wr = 1'b1;
			res = '0;
			case (ir[15:12])
				add_op: res = r[ir[8:6]] + b;
				and_op: res = r[ir[8:6]] & b;
				4'b1001: res = ~r[ir[8:6]];
				4'b0110: res = mem[addr[8:1]];
				4'b0111: begin
					wr = 1'b0;
					mem[addr[8:1]] = r[ir[11:9]];
					expected.push_back({addr, r[ir[11:9]]});
				end
				default: begin
					wr = 1'b0;
					if ((ir[11:9] & cc) != 3'b000) begin
						if (target == pc - 16'd2) begin
							halt_pc = target;
							break;
						end
						pc = target;
					end
				end
			endcase
			if (wr) begin
				r[ir[11:9]] = res;
				cc = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
			end
		end
	endfunction

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		foreach (image[i]) i_memory.mem[i] = image[i];
		store_idx = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!reset && store_valid) begin
			assert (store_idx < expected.size()) else begin
				$display("Unexpected extra store to %h in %s", store_addr, test_name);
				$display("Simulation failed");
				$fatal(1, "extra store");
			end
			assert (store_addr == expected[store_idx].addr) else begin
				$display("FAIL %s store %0d address: expected %h, actual %h", test_name,
					store_idx, expected[store_idx].addr, store_addr);
				$display("Simulation failed");
				$fatal(1, "address mismatch");
			end
			assert (store_data == expected[store_idx].data) else begin
				$display("FAIL %s store %0d data: expected %h, actual %h", test_name,
					store_idx, expected[store_idx].data, store_data);
				$display("Simulation failed");
				$fatal(1, "data mismatch");
			end
			store_idx++;
		end
	end

	// No store may reach the data port before a STR has even been fetched
	always @(posedge clk) begin
		if (reset || !str_fetched) begin
			assert (data_write !== 1'b1) else begin
				$display("data_write went high before any store instruction was fetched");
				$display("Simulation failed");
				$fatal(1, "early data_write");
			end
		end
		if (reset) str_fetched <= 1'b0;
		else if (inst_resp && inst_rdata[15:12] == 4'b0111) str_fetched <= 1'b1;
	end

	// Two answered fetches of the halt branch show the program has settled in its last loop
	always @(posedge clk) begin
		if (reset) halt_fetches <= 0;
		else if (inst_resp && inst_address == halt_pc) halt_fetches <= halt_fetches + 1;
	end

	initial begin
		reset = 1'b1;
		random_delay = 1'b0;
		store_idx = 0;
		build_program();
		for (int i = 0; i < mem_words; i++) begin
			image[i] = 16'(i * 16'h2F1B) ^ 16'hA5C3;
		end
		foreach (prog[i]) image[i] = prog[i];
		compute_expected();
		limit = 12 * prog.size() + 50;
		for (int run = 0; run < 2; run++) begin
			test_name = (run == 0) ? "single_cycle_latency" : "random_latency";
			random_delay = (run == 1);
			apply_reset();
			cycles = 0;
			while (store_idx < expected.size() || halt_fetches < 2) begin
				@(negedge clk);
				cycles++;
				assert (cycles <= limit) else begin
					$display("Timeout in %s: %0d of %0d stores seen, halt fetched %0d times, after %0d cycles",
						test_name, store_idx, expected.size(), halt_fetches, cycles);
					$display("Simulation failed");
					$fatal(1, "timeout");
				end
			end
		end
		$display("Simulation passed");
		$finish;
	end
endmodule

// File: testbench/tb_lc3b_memory.sv
module tb_lc3b_memory (
	input logic clk,
	input logic reset,
	input logic random_delay,
	input lc3b_types::lc3b_word inst_address,
	input logic inst_read,
	output logic inst_resp,
	output lc3b_types::lc3b_word inst_rdata,
	input lc3b_types::lc3b_word data_address,
	input lc3b_types::lc3b_word data_wdata,
	input logic data_read,
	input logic data_write,
	output logic data_resp,
	output lc3b_types::lc3b_word data_rdata,
	output logic store_valid,
	output lc3b_types::lc3b_word store_addr,
	output lc3b_types::lc3b_word store_data
);
	timeunit 1ns;
	timeprecision 1ps;
	import lc3b_types::*;

	lc3b_word mem [256];
	logic [15:0] lfsr = 16'd45;
	int inst_left;
	int data_left;
	logic inst_done, data_done;
	logic inst_req_q, data_req_q;	// Requests seen in the cycle that just ended
	logic advance;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Latency of 1 to 3 cycles, one LFSR step per bit
	function automatic int pick_delay();
		int d;
		d = 1;
		if (random_delay) begin
			repeat (2) begin
				lfsr = lfsr_next(lfsr);
				d += lfsr[0];
			end
		end
		return d;
	endfunction

	initial begin
		inst_resp = 1'b0;
		data_resp = 1'b0;
		inst_rdata = '0;
		data_rdata = '0;
		store_valid = 1'b0;
		store_addr = '0;
		store_data = '0;
	end

	always @(negedge clk) begin
		if (reset) begin
			{inst_resp, data_resp, store_valid} = 3'b000;
			{inst_done, data_done, inst_req_q, data_req_q} = 4'b0000;
			inst_left = 0;
			data_left = 0;
		end else begin
			// The CPU advanced at the last edge if nothing was left waiting
			advance = !((inst_req_q && !inst_resp && !inst_done) ||
				(data_req_q && !data_resp && !data_done));
			if (advance) begin
				{inst_done, data_done} = 2'b00;
				inst_left = 0;
				data_left = 0;
			end else begin
				inst_done = inst_done | inst_resp;
				data_done = data_done | data_resp;
			end
			{inst_resp, data_resp, store_valid} = 3'b000;
			inst_req_q = inst_read;
			data_req_q = data_read | data_write;

			if (inst_read && !inst_done) begin
				if (inst_left == 0) inst_left = pick_delay();
				inst_left--;
				if (inst_left == 0) begin
					inst_resp = 1'b1;
					inst_rdata = mem[inst_address[8:1]];	// Held until the next answer
				end
			end

			if (data_req_q && !data_done) begin
				if (data_left == 0) data_left = pick_delay();
				data_left--;
				if (data_left == 0) begin
					data_resp = 1'b1;
					if (data_write) begin
						mem[data_address[8:1]] = data_wdata;
						store_valid = 1'b1;
						store_addr = data_address;
						store_data = data_wdata;
					end else begin
						data_rdata = mem[data_address[8:1]];
					end
				end
			end
		end
	end
endmodule

// File: hdl/lc3b_cpu.sv
module lc3b_cpu (
	input logic clk,
	input logic reset,
	output lc3b_types::lc3b_word inst_address,
	output logic inst_read,
	input logic inst_resp,
	input lc3b_types::lc3b_word inst_rdata,
	output lc3b_types::lc3b_word data_address,
	output lc3b_types::lc3b_word data_wdata,
	output logic data_read,
	output logic data_write,
	input logic data_resp,
	input lc3b_types::lc3b_word data_rdata
);
	logic stall;	// Freezes every stage while either port waits

	datapath i_datapath (
		.clk,
		.reset,
		.stall(stall),
		.inst_rdata(inst_rdata),
		.data_rdata(data_rdata),
		.inst_address(inst_address),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.inst_read(inst_read),
		.data_read(data_read),
		.data_write(data_write)
	);

	mem_stall i_mem_stall (
		.clk,
		.reset,
		.inst_read(inst_read),
		.inst_resp(inst_resp),
		.data_read(data_read),
		.data_write(data_write),
		.data_resp(data_resp),
		.stall(stall)
	);
endmodule

// File: hdl/datapath.sv
`include "lc3b_defs.svh"

module datapath (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_types::lc3b_word inst_rdata,
	input lc3b_types::lc3b_word data_rdata,
	output lc3b_types::lc3b_word inst_address,
	output lc3b_types::lc3b_word data_address,
	output lc3b_types::lc3b_word data_wdata,
	output logic inst_read,
	output logic data_read,
	output logic data_write
);
	import lc3b_types::*;

	logic fetch_en;
	logic use_imm;
	logic branch_taken;
	lc3b_reg src_b;
	lc3b_word pc, pc_plus2, pc_next, ir;
	lc3b_word reg_a_out, reg_b_out, sext_out;
	lc3b_word id_pc, id_sr1, id_sr2, id_sext;
	lc3b_word alu_b, alu_out, branch_target;
	lc3b_word ex_alu, ex_wdata, ex_target;
	lc3b_word mem_alu, mem_data, wb_data;
	lc3b_control_word gen_ctrl, id_ctrl, ex_ctrl, mem_ctrl;
	lc3b_passed_vals gen_passed, id_passed, ex_passed, mem_passed;

	assign pc_plus2 = pc + `LC3B_WIDTH'(2);
	assign pc_next = (ex_ctrl.pc_sel && branch_taken) ? ex_target : pc_plus2;

	// PC and IR move only on a live fetch, so IR stays NOP the cycle after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_en <= 1'b0;
			pc <= `LC3B_RESET_PC;
			ir <= `LC3B_NOP;
		end else begin
			fetch_en <= 1'b1;
			if (fetch_en && !stall) begin
				pc <= pc_next;
				ir <= inst_rdata;
			end
		end
	end

	control_rom i_control_rom (.ir(ir), .ctrl(gen_ctrl), .passed(gen_passed));

	assign src_b = gen_ctrl.src_b_mux_sel ? ir[11:9] : ir[2:0];

	always_comb begin
		case (gen_ctrl.sext_sel)
			2'd0: sext_out = {{11{ir[4]}}, ir[4:0]};
			2'd1: sext_out = {{9{ir[5]}}, ir[5:0], 1'b0};	// Word offset in bytes
			2'd2: sext_out = {{7{ir[8]}}, ir[8:0]};
			default: sext_out = '0;
		endcase
	end

	regfile i_regfile (
		.clk, .reset,
		.load(mem_ctrl.load_regfile & ~stall),
		.in(wb_data),
		.src_a(ir[8:6]),
		.src_b(src_b),
		.dest(mem_passed.dest),
		.reg_a(reg_a_out),
		.reg_b(reg_b_out)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			id_ctrl <= '0;
			id_passed <= '0;
			ex_ctrl <= '0;
			ex_passed <= '0;
			mem_ctrl <= '0;
			mem_passed <= '0;
		end else if (!stall) begin
			id_ctrl <= gen_ctrl;
			id_passed <= gen_passed;
			ex_ctrl <= id_ctrl;
			ex_passed <= id_passed;
			mem_ctrl <= ex_ctrl;
			mem_passed <= ex_passed;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc <= pc;	// PC already points one word past the instruction in IR
			id_sr1 <= reg_a_out;
			id_sr2 <= reg_b_out;
			id_sext <= sext_out;
			ex_alu <= alu_out;
			ex_wdata <= id_sr2;
			ex_target <= branch_target;
			mem_alu <= ex_alu;
			mem_data <= data_rdata;
		end
	end

	assign use_imm = (id_ctrl.opcode inside {op_ldr, op_str}) ||
		(id_passed.ir_5 && (id_ctrl.opcode inside {op_add, op_and}));
	assign alu_b = use_imm ? id_sext : id_sr2;
	assign branch_target = id_pc + {id_sext[14:0], 1'b0};

	alu i_alu (.aluop(id_ctrl.aluop), .a(id_sr1), .b(alu_b), .f(alu_out));

	assign wb_data = mem_ctrl.wb_sel ? mem_data : mem_alu;

	cc_unit i_cc_unit (
		.clk, .reset,
		.load(mem_ctrl.load_cc & ~stall),
		.result(wb_data),
		.nzp(ex_passed.nzp),
		.branch_taken(branch_taken)
	);

	assign inst_address = pc;
	assign inst_read = fetch_en;
	assign data_address = ex_alu;
	assign data_wdata = ex_wdata;
	assign data_read = ex_ctrl.mem_read;
	assign data_write = ex_ctrl.mem_write;
endmodule

// File: hdl/mem_stall.sv
module mem_stall (
	input logic clk,
	input logic reset,
	input logic inst_read,
	input logic inst_resp,
	input logic data_read,
	input logic data_write,
	input logic data_resp,
	output logic stall
);
	logic data_req;
	logic inst_done;	// Answered, but the other port still holds the pipeline
	logic data_done;
	logic inst_wait;
	logic data_wait;

	assign data_req = data_read | data_write;
	assign inst_wait = inst_read & ~inst_resp & ~inst_done;
	assign data_wait = data_req & ~data_resp & ~data_done;
	assign stall = inst_wait | data_wait;

	// Flags clear once the pipeline advances and new requests go out
	always_ff @(posedge clk) begin
		if (reset || !stall) begin
			inst_done <= 1'b0;
			data_done <= 1'b0;
		end else begin
			inst_done <= inst_done | inst_resp;
			data_done <= data_done | data_resp;
		end
	end

	inst_resp_with_req: assert property (@(posedge clk) disable iff (reset)
		inst_resp |-> inst_read);
	data_resp_with_req: assert property (@(posedge clk) disable iff (reset)
		data_resp |-> data_req);
	data_one_op: assert property (@(posedge clk) disable iff (reset)
		!(data_read && data_write));

	// The frozen datapath must keep an unanswered request raised
	inst_req_held: assert property (@(posedge clk) disable iff (reset)
		inst_wait |=> inst_read);
	data_req_held: assert property (@(posedge clk) disable iff (reset)
		data_wait |=> data_req);
endmodule

// File: hdl/cc_unit.sv
module cc_unit (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::lc3b_word result,
	input lc3b_types::lc3b_nzp nzp,
	output logic branch_taken
);
	import lc3b_types::*;

	lc3b_nzp gen_cc;
	lc3b_nzp cc;

	always_comb begin
		if (result[15]) begin
			gen_cc = 3'b100;
		end else if (result == '0) begin
			gen_cc = 3'b010;
		end else begin
			gen_cc = 3'b001;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cc <= 3'b010;
		end else if (load) begin
			cc <= gen_cc;
		end
	end

	assign branch_taken = |(nzp & cc);

	// Exactly one flag holds across every writeback
	cc_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(cc))
		else $error("cc register not one-hot: %b", cc);
endmodule

// File: hdl/alu.sv
module alu (
	input lc3b_types::lc3b_aluop aluop,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f
);
	import lc3b_types::*;

	always_comb begin
		unique case (aluop)
			alu_add: begin
				f = a + b;	// Also forms base plus offset for LDR and STR
			end
			alu_and: begin
				f = a & b;
			end
			alu_not: begin
				f = ~a;
			end
			alu_pass: begin
				f = b;
			end
		endcase
	end
endmodule

// File: hdl/regfile.sv
`include "lc3b_defs.svh"

module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	input lc3b_types::lc3b_reg dest,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word regs [`LC3B_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (load) begin
			regs[dest] <= in;
		end
	end

	// No bypass, a written value shows up the cycle after the edge
	assign reg_a = regs[src_a];
	assign reg_b = regs[src_b];
endmodule

// File: hdl/control_rom.sv
module control_rom (
	input lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_control_word ctrl,
	output lc3b_types::lc3b_passed_vals passed
);
	import lc3b_types::*;

	lc3b_opcode opcode;

	assign opcode = lc3b_opcode'(ir[15:12]);

	always_comb begin
		ctrl = '0;	// Unknown opcodes fall through as NOP
		case (opcode)
			op_add, op_and: begin
				ctrl.opcode = opcode;
				ctrl.aluop = (opcode == op_add) ? alu_add : alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_not: begin
				ctrl.opcode = op_not;
				ctrl.aluop = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_ldr: begin
				ctrl.opcode = op_ldr;
				ctrl.aluop = alu_add;
				ctrl.sext_sel = 2'd1;
				ctrl.mem_read = 1'b1;
				ctrl.wb_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_str: begin
				ctrl.opcode = op_str;
				ctrl.aluop = alu_add;
				ctrl.sext_sel = 2'd1;
				ctrl.src_b_mux_sel = 1'b1;	// Store data comes from SR in ir[11:9]
				ctrl.mem_write = 1'b1;
			end
			op_br: begin
				// A BR without condition bits decodes to the plain NOP word
				if (|ir[11:9]) begin
					ctrl.sext_sel = 2'd2;
					ctrl.pc_sel = 1'b1;
				end
			end
			default: ;
		endcase
	end

	assign passed.dest = ir[11:9];
	assign passed.nzp = (opcode == op_br) ? ir[11:9] : 3'b000;
	assign passed.ir_5 = ir[5];
endmodule

// File: hdl/lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;	// n, z, p from msb down

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	// An all-zero word is the NOP control
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop aluop;
		logic [1:0] sext_sel;	// 0 imm5, 1 offset6 scaled, 2 offset9
		logic src_b_mux_sel;	// High reads ir[11:9] as source B
		logic mem_read;
		logic mem_write;
		logic wb_sel;	// High writes back the load data
		logic load_regfile;
		logic load_cc;
		logic pc_sel;
	} lc3b_control_word;

	typedef struct packed {
		lc3b_reg dest;
		lc3b_nzp nzp;
		logic ir_5;
	} lc3b_passed_vals;

endpackage : lc3b_types

// File: hdl/lc3b_defs.svh
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// Word width of the datapath and both memory ports
`define LC3B_WIDTH 16

`define LC3B_NUM_REGS 8

// First fetch address after reset
`define LC3B_RESET_PC 16'h0000

// BR with n, z and p all clear, so it never branches
`define LC3B_NOP 16'h0000

`endif
